// ==== Bender.yml ====
package:
  name: rv32_core

sources:
  - riscv_isa_pkg.sv
  - core_ctrl_pkg.sv
  - inst_decoder.sv
  - alu_branch.sv
  - writeback_regfile.sv
  - rv32_core.sv
  - target: test
    files:
      - rv32_core_properties.sv
      - tb_rv32_core.sv

// ==== alu_branch.sv ====
`timescale 1ns/100ps
module alu_branch (
    input  core_ctrl_pkg::alu_op_e  alu_op_i,
    input  core_ctrl_pkg::br_op_e   br_op_i,
    input  core_ctrl_pkg::op1_sel_e op1_sel_i,
    input  core_ctrl_pkg::op2_sel_e op2_sel_i,
    input  riscv_isa_pkg::word_t    pc_i,
    input  riscv_isa_pkg::word_t    rs1_data_i,
    input  riscv_isa_pkg::word_t    rs2_data_i,
    input  riscv_isa_pkg::word_t    imm_i_i,
    input  riscv_isa_pkg::word_t    imm_s_i,
    input  riscv_isa_pkg::word_t    imm_j_i,
    input  riscv_isa_pkg::word_t    imm_u_i,
    input  riscv_isa_pkg::word_t    imm_b_i,
    output riscv_isa_pkg::word_t    alu_result_o,
    output logic                    br_taken_o,
    output riscv_isa_pkg::word_t    br_target_o
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t      op1;
    word_t      op2;
    word_t      sum;
    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    always_comb begin
        case (op1_sel_i)
            OP1_PC:   op1 = pc_i;
            OP1_ZERO: op1 = '0; // lui
            default:  op1 = rs1_data_i;
        endcase
    end

    always_comb begin
        case (op2_sel_i)
            OP2_IMM_I: op2 = imm_i_i;
            OP2_IMM_S: op2 = imm_s_i;
            OP2_IMM_J: op2 = imm_j_i;
            OP2_IMM_U: op2 = imm_u_i;
            default:   op2 = rs2_data_i;
        endcase
    end

    assign sum   = op1 + op2;
    assign shamt = op2[4:0];

    // branches select rs1/rs2, so one comparator serves slt and branch
    assign eq   = op1 == op2;
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:      alu_result_o = op1 - op2;
            ALU_AND:      alu_result_o = op1 & op2;
            ALU_OR:       alu_result_o = op1 | op2;
            ALU_XOR:      alu_result_o = op1 ^ op2;
            ALU_SLL:      alu_result_o = op1 << shamt;
            ALU_SRL:      alu_result_o = op1 >> shamt;
            ALU_SRA:      alu_result_o = $signed(op1) >>> shamt;
            ALU_SLT:      alu_result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:     alu_result_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_JALR_ADD: alu_result_o = {sum[XLEN-1:1], 1'b0};
            default:      alu_result_o = sum;
        endcase
    end

    always_comb begin
        case (br_op_i)
            BR_BEQ:  br_taken_o = eq;
            BR_BNE:  br_taken_o = !eq;
            BR_BLT:  br_taken_o = lt_s;
            BR_BGE:  br_taken_o = !lt_s;
            BR_BLTU: br_taken_o = lt_u;
            BR_BGEU: br_taken_o = !lt_u;
            default: br_taken_o = 1'b0;
        endcase
    end

    assign br_target_o = pc_i + imm_b_i;

endmodule

// ==== core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_JALR_ADD // sum with bit 0 cleared
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;

    typedef enum logic [2:0] {OP2_RS2, OP2_IMM_I, OP2_IMM_S, OP2_IMM_J, OP2_IMM_U} op2_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS4} wb_sel_e;

    typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_MEM_WAIT, ST_HALTED} core_state_e;

endpackage

// ==== inst_decoder.sv ====
`timescale 1ns/100ps
module inst_decoder (
    input  riscv_isa_pkg::inst_t     inst_i,
    output core_ctrl_pkg::alu_op_e   alu_op_o,
    output core_ctrl_pkg::br_op_e    br_op_o,
    output core_ctrl_pkg::op1_sel_e  op1_sel_o,
    output core_ctrl_pkg::op2_sel_e  op2_sel_o,
    output core_ctrl_pkg::wb_sel_e   wb_sel_o,
    output logic                     rf_wen_o,
    output logic                     mem_wen_o,
    output logic                     is_jump_o,
    output riscv_isa_pkg::reg_addr_t rs1_o,
    output riscv_isa_pkg::reg_addr_t rs2_o,
    output riscv_isa_pkg::reg_addr_t rd_o,
    output riscv_isa_pkg::word_t     imm_i_o,
    output riscv_isa_pkg::word_t     imm_s_o,
    output riscv_isa_pkg::word_t     imm_b_o,
    output riscv_isa_pkg::word_t     imm_j_o,
    output riscv_isa_pkg::word_t     imm_u_o
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       op_ok;
    logic       imm_ok;

    function automatic alu_op_e alu_fn(funct3_t f3, logic sel_alt);
        case (f3)
            F3_ADD_SUB: return sel_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return sel_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign alt    = funct7 == F7_ALT;

    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o  = inst_i[11:7];

    assign imm_i_o = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u_o = {inst_i[31:12], 12'b0};

    // alt funct7 only legal on sub and sra
    assign op_ok = funct7 == 7'b0 || (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));

    always_comb begin
        case (funct3)
            F3_SLL:     imm_ok = funct7 == 7'b0;
            F3_SRL_SRA: imm_ok = funct7 == 7'b0 || alt;
            default:    imm_ok = 1'b1; // upper bits are immediate
        endcase
    end

    always_comb begin
        // no-op unless matched
        alu_op_o  = ALU_ADD;
        br_op_o   = BR_NONE;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_RS2;
        wb_sel_o  = WB_ALU;
        rf_wen_o  = 1'b0;
        mem_wen_o = 1'b0;
        is_jump_o = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (op_ok) begin
                    alu_op_o = alu_fn(funct3, alt);
                    rf_wen_o = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (imm_ok) begin
                    alu_op_o  = alu_fn(funct3, alt && funct3 == F3_SRL_SRA);
                    op2_sel_o = OP2_IMM_I;
                    rf_wen_o  = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_LW) begin
                    op2_sel_o = OP2_IMM_I;
                    wb_sel_o  = WB_MEM;
                    rf_wen_o  = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_SW) begin
                    op2_sel_o = OP2_IMM_S;
                    mem_wen_o = 1'b1;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  br_op_o = BR_BEQ;
                    F3_BNE:  br_op_o = BR_BNE;
                    F3_BLT:  br_op_o = BR_BLT;
                    F3_BGE:  br_op_o = BR_BGE;
                    F3_BLTU: br_op_o = BR_BLTU;
                    F3_BGEU: br_op_o = BR_BGEU;
                    default: br_op_o = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMM_J;
                wb_sel_o  = WB_PC_PLUS4;
                rf_wen_o  = 1'b1;
                is_jump_o = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    alu_op_o  = ALU_JALR_ADD;
                    op2_sel_o = OP2_IMM_I;
                    wb_sel_o  = WB_PC_PLUS4;
                    rf_wen_o  = 1'b1;
                    is_jump_o = 1'b1;
                end
            end
            OPC_LUI: begin
                op1_sel_o = OP1_ZERO;
                op2_sel_o = OP2_IMM_U;
                rf_wen_o  = 1'b1;
            end
            OPC_AUIPC: begin
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMM_U;
                rf_wen_o  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;

    // major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // integer ops, shared by reg and imm forms
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_LW   = 3'b010; // word only
    localparam funct3_t F3_SW   = 3'b010;
    localparam funct3_t F3_JALR = 3'b000;

    localparam logic [6:0] F7_ALT = 7'b0100000; // sub / sra

    localparam reg_addr_t REG_GP = 5'd3;

endpackage

// ==== rv32_core.sv ====
`timescale 1ns/100ps
module rv32_core #(
    parameter riscv_isa_pkg::word_t EXIT_PC  = 32'h44,
    parameter riscv_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output riscv_isa_pkg::word_t imem_addr_o,
    input  riscv_isa_pkg::word_t imem_rdata_i,
    output riscv_isa_pkg::word_t dmem_addr_o,
    output logic                 dmem_wen_o,
    output riscv_isa_pkg::word_t dmem_wdata_o,
    input  riscv_isa_pkg::word_t dmem_rdata_i,
    output logic                 halt_o,
    output riscv_isa_pkg::word_t gp_o
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    core_state_e state;
    core_state_e state_nxt;
    word_t       pc;
    word_t       pc_plus4;
    word_t       pc_nxt;

    alu_op_e   alu_op;
    br_op_e    br_op;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    wb_sel_e   wb_sel;
    logic      rf_wen;
    logic      mem_wen;
    logic      is_jump;
    logic      is_load;
    logic      retire;
    logic      br_taken;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_j;
    word_t     imm_u;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    word_t     br_target;

    inst_decoder u_decoder (
        .inst_i    (imem_rdata_i),
        .alu_op_o  (alu_op),
        .br_op_o   (br_op),
        .op1_sel_o (op1_sel),
        .op2_sel_o (op2_sel),
        .wb_sel_o  (wb_sel),
        .rf_wen_o  (rf_wen),
        .mem_wen_o (mem_wen),
        .is_jump_o (is_jump),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .rd_o      (rd),
        .imm_i_o   (imm_i),
        .imm_s_o   (imm_s),
        .imm_b_o   (imm_b),
        .imm_j_o   (imm_j),
        .imm_u_o   (imm_u)
    );

    alu_branch u_alu (
        .alu_op_i     (alu_op),
        .br_op_i      (br_op),
        .op1_sel_i    (op1_sel),
        .op2_sel_i    (op2_sel),
        .pc_i         (pc),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imm_i_i      (imm_i),
        .imm_s_i      (imm_s),
        .imm_j_i      (imm_j),
        .imm_u_i      (imm_u),
        .imm_b_i      (imm_b),
        .alu_result_o (alu_result),
        .br_taken_o   (br_taken),
        .br_target_o  (br_target)
    );

    writeback_regfile u_regfile (
        .clk          (clk),
        .rst_n        (rst_n),
        .wen_i        (rf_wen && retire),
        .rd_i         (rd),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .wb_sel_i     (wb_sel),
        .alu_result_i (alu_result),
        .mem_rdata_i  (dmem_rdata_i),
        .pc_plus4_i   (pc_plus4),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .gp_o         (gp_o)
    );

    assign pc_plus4 = pc + 32'd4;
    assign is_load  = wb_sel == WB_MEM;
    // last cycle of the instruction
    assign retire   = (state == ST_EXEC && !is_load) || state == ST_MEM_WAIT;

    always_comb begin
        if (br_taken) begin
            pc_nxt = br_target;
        end else if (is_jump) begin
            pc_nxt = alu_result;
        end else begin
            pc_nxt = pc_plus4;
        end
    end

    always_comb begin
        case (state)
            ST_FETCH:    state_nxt = (pc == EXIT_PC) ? ST_HALTED : ST_EXEC;
            ST_EXEC:     state_nxt = is_load ? ST_MEM_WAIT : ST_FETCH;
            ST_MEM_WAIT: state_nxt = ST_FETCH;
            default:     state_nxt = ST_HALTED; // until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_nxt;
            if (retire) begin
                pc <= pc_nxt;
            end
        end
    end

    // pc held through exec, so rdata stays on the current instruction
    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_wen_o   = mem_wen && state == ST_EXEC;
    assign halt_o       = state == ST_HALTED;

endmodule

// ==== rv32_core_properties.sv ====
`timescale 1ns/100ps
module rv32_core_properties (
    input logic                      clk,
    input logic                      rst_n,
    input core_ctrl_pkg::core_state_e state_i,
    input logic                      dmem_wen_i,
    input logic                      halt_i,
    input riscv_isa_pkg::word_t      imem_addr_i
);
    import core_ctrl_pkg::*;

    int err_count = 0; // failures so far

    // stores only during exec, the one cycle between two fetches
    wen_in_exec: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_wen_i |=> state_i == ST_FETCH && $past(state_i, 2) == ST_FETCH)
        else begin
            $error("dmem_wen_o high outside exec");
            err_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halt_i |=> halt_i)
        else begin
            $error("halt_o dropped without reset");
            err_count++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        state_i == ST_FETCH |-> imem_addr_i[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            err_count++;
        end

endmodule

// ==== tb.f ====
riscv_isa_pkg.sv
core_ctrl_pkg.sv
inst_decoder.sv
alu_branch.sv
writeback_regfile.sv
rv32_core.sv
rv32_core_properties.sv
tb_rv32_core.sv

// ==== tb_rv32_core.sv ====
`timescale 1ns/100ps
module tb_rv32_core;
    import riscv_isa_pkg::*;

    localparam word_t EXIT_ADDR  = 32'h44;
    localparam int    MAX_CYCLES = 200;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    typedef enum int {K_OP, K_OP_IMM, K_BRANCH, K_JAL, K_JALR, K_MEM, K_AUIPC} kind_e;

    logic  clk;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    logic  dmem_wen;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  halt;
    word_t gp;

    word_t imem [32];
    word_t dmem [256];
    word_t prog [$];

    // case table
    kind_e      kind_q [$];
    logic [3:0] code_q [$]; // {alt, funct3}
    word_t      a_q [$];
    word_t      b_q [$];
    word_t      exp_q [$];

    word_t corner_a [4] = '{32'h0, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
    word_t corner_b [4] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h0000_001f};
    word_t rng_state;

    int    wr_count;
    word_t wr_addr;
    word_t wr_data;

    rv32_core #(
        .EXIT_PC  (EXIT_ADDR),
        .RESET_PC (32'h0)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_wen_o   (dmem_wen),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata),
        .halt_o       (halt),
        .gp_o         (gp)
    );

    bind rv32_core rv32_core_properties props0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .state_i     (state),
        .dmem_wen_i  (dmem_wen_o),
        .halt_i      (halt_o),
        .imem_addr_i (imem_addr_o)
    );

    always #50 clk = ~clk;

    // one cycle read latency, writes land on the edge
    always @(posedge clk) begin : mem_model
        word_t ia;
        word_t da;
        ia = imem_addr;
        da = dmem_addr;
        if (dmem_wen === 1'b1) begin
            dmem[da[9:2]] = dmem_wdata;
            wr_count      = wr_count + 1;
            wr_addr       = da;
            wr_data       = dmem_wdata;
        end
        #10;
        imem_rdata = imem[ia[6:2]];
        dmem_rdata = dmem[da[9:2]];
    end

    function automatic word_t xorshift(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic word_t enc_r(logic [3:0] code, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [4:0] rd);
        return {1'b0, code[3], 5'b0, rs2, rs1, code[2:0], rd, OP_REG};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    // always compares x1 with x2
    function automatic word_t enc_b(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t jump_to_exit(word_t pc);
        word_t off;
        off = EXIT_ADDR - pc;
        return enc_j(off[20:0], 5'd0);
    endfunction

    function automatic logic [11:0] imm_field(logic [3:0] code, word_t b);
        if (code[1:0] == 2'b01) begin
            return {1'b0, code[3], 5'b0, b[4:0]}; // shift amount form
        end else begin
            return b[11:0];
        end
    endfunction

    function automatic word_t alu_ref(logic [3:0] code, word_t a, word_t b);
        case (code[2:0])
            3'b000:  return code[3] ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (code[3]) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t expected_for(kind_e k, logic [3:0] code, word_t a, word_t b);
        word_t imm;
        imm = {{20{b[11]}}, b[11:0]};
        case (k)
            K_OP:     return alu_ref(code, a, b);
            K_OP_IMM: return alu_ref(code, a, imm);
            K_BRANCH: return branch_ref(code[2:0], a, b) ? 32'd0 : 32'd1;
            K_JAL:    return 32'd12; // jal sits at 8
            K_JALR:   return 32'd8;  // jalr sits at 4
            K_MEM:    return a;
            default:  return 32'd4 + {a[31:12], 12'h000};
        endcase
    endfunction

    task automatic push_li(logic [4:0] rd, word_t v);
        word_t hi;
        hi = v + 32'h800; // addi sign-extends the low part
        prog.push_back(enc_u(hi[31:12], rd, OP_LUI));
        prog.push_back(enc_i(v[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic push_exit();
        prog.push_back(jump_to_exit(4 * prog.size()));
    endtask

    task automatic build_program(kind_e k, logic [3:0] code, word_t a, word_t b);
        prog = {};
        case (k)
            K_OP: begin
                push_li(5'd1, a);
                push_li(5'd2, b);
                prog.push_back(enc_r(code, 5'd2, 5'd1, 5'd3));
            end
            K_OP_IMM: begin
                push_li(5'd1, a);
                prog.push_back(enc_i(imm_field(code, b), 5'd1, code[2:0], 5'd3, OP_IMM));
            end
            K_BRANCH: begin
                push_li(5'd1, a);
                push_li(5'd2, b);
                prog.push_back(enc_b(13'd8, code[2:0]));
                prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd3, OP_IMM)); // skipped if taken
            end
            K_JAL: begin
                push_li(5'd1, a);
                prog.push_back(enc_j(21'd8, 5'd5));
                push_exit();
                prog.push_back(enc_i(12'd0, 5'd5, 3'b000, 5'd3, OP_IMM));
            end
            K_JALR: begin
                prog.push_back(enc_i(12'd16, 5'd0, 3'b000, 5'd1, OP_IMM));
                prog.push_back(enc_i(12'd5, 5'd1, 3'b000, 5'd5, OP_JALR)); // 21 lands on 20
                push_exit();
                push_exit();
                push_exit();
                prog.push_back(enc_i(12'd0, 5'd5, 3'b000, 5'd3, OP_IMM));
            end
            K_MEM: begin
                push_li(5'd1, a);
                push_li(5'd2, {22'b0, b[9:3], 3'b000});
                prog.push_back(enc_s(12'd4, 5'd1, 5'd2));
                prog.push_back(enc_i(12'd4, 5'd2, 3'b010, 5'd3, OP_LOAD));
            end
            default: begin
                prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd0, OP_IMM));
                prog.push_back(enc_u(a[31:12], 5'd3, OP_AUIPC));
            end
        endcase
        push_exit();
    endtask

    task automatic load_memories();
        int i;
        for (i = 0; i < 32; i++) begin
            if (i < prog.size()) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = jump_to_exit(4 * i); // stray fetches end the run
            end
        end
        for (i = 0; i < 256; i++) begin
            dmem[i] = 32'hc0de_0000 | (i << 2);
        end
    endtask

    task automatic add_rows(kind_e k, logic [3:0] code);
        int    i;
        word_t a;
        word_t b;
        for (i = 0; i < 6; i++) begin
            if (i < 4) begin
                a = corner_a[i];
                b = corner_b[i];
            end else begin
                a = next_rand();
                b = next_rand();
            end
            kind_q.push_back(k);
            code_q.push_back(code);
            a_q.push_back(a);
            b_q.push_back(b);
            exp_q.push_back(expected_for(k, code, a, b));
        end
    endtask

    task automatic build_table();
        logic [3:0] op_codes [10]  = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
        logic [3:0] imm_codes [9]  = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hd};
        logic [3:0] br_codes [6]   = '{4'h0, 4'h1, 4'h4, 4'h5, 4'h6, 4'h7};
        foreach (op_codes[i]) begin
            add_rows(K_OP, op_codes[i]);
        end
        foreach (imm_codes[i]) begin
            add_rows(K_OP_IMM, imm_codes[i]);
        end
        foreach (br_codes[i]) begin
            add_rows(K_BRANCH, br_codes[i]);
        end
        add_rows(K_JAL, 4'h0);
        add_rows(K_JALR, 4'h0);
        add_rows(K_MEM, 4'h0);
        add_rows(K_AUIPC, 4'h0);
    endtask

    task automatic check_value(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_reset();
        int i;
        rst_n = 1'b0;
        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            #10;
        end
        rst_n = 1'b1;
    endtask

    task automatic run_case(int r);
        int    cycles;
        int    i;
        string tag;
        tag = $sformatf("case %0d %s", r, kind_q[r].name());
        build_program(kind_q[r], code_q[r], a_q[r], b_q[r]);
        load_memories();
        apply_reset();
        wr_count = 0;
        check_value(imem_addr, 32'h0, {tag, " imem_addr_o after reset"});
        check_value(dmem_wen, 0, {tag, " dmem_wen_o after reset"});
        check_value(halt, 0, {tag, " halt_o after reset"});
        check_value(gp, 0, {tag, " gp_o after reset"});
        cycles = 0;
        while (halt !== 1'b1) begin
            if (cycles == MAX_CYCLES) begin
                $display("%s: core did not halt within %0d cycles", tag, MAX_CYCLES);
                $display("Result: FAILED");
                $fatal(1, "halt timeout");
            end
            @(posedge clk);
            #10;
            cycles++;
        end
        check_value(gp, exp_q[r], {tag, " gp_o"});
        check_value(wr_count, (kind_q[r] == K_MEM) ? 1 : 0, {tag, " store count"});
        if (kind_q[r] == K_MEM) begin
            check_value(wr_addr, {22'b0, b_q[r][9:3], 3'b100}, {tag, " store address"});
            check_value(wr_data, a_q[r], {tag, " store data"});
        end
        // halted core must stay parked
        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            #10;
            check_value(imem_addr, EXIT_ADDR, {tag, " imem_addr_o while halted"});
            check_value(halt, 1, {tag, " halt_o while halted"});
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        rng_state  = 32'd10381;
        wr_count   = 0;
        build_table();
        for (int r = 0; r < kind_q.size(); r++) begin
            run_case(r);
        end
        if (dut0.props0.err_count != 0) begin
            $display("bound assertions failed %0d times", dut0.props0.err_count);
            $display("Result: FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== writeback_regfile.sv ====
`timescale 1ns/100ps
module writeback_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wen_i,
    input  riscv_isa_pkg::reg_addr_t rd_i,
    input  riscv_isa_pkg::reg_addr_t rs1_i,
    input  riscv_isa_pkg::reg_addr_t rs2_i,
    input  core_ctrl_pkg::wb_sel_e   wb_sel_i,
    input  riscv_isa_pkg::word_t     alu_result_i,
    input  riscv_isa_pkg::word_t     mem_rdata_i,
    input  riscv_isa_pkg::word_t     pc_plus4_i,
    output riscv_isa_pkg::word_t     rs1_data_o,
    output riscv_isa_pkg::word_t     rs2_data_o,
    output riscv_isa_pkg::word_t     gp_o
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t regs [32];
    word_t wb_data;

    always_comb begin
        case (wb_sel_i)
            WB_MEM:      wb_data = mem_rdata_i;
            WB_PC_PLUS4: wb_data = pc_plus4_i; // link address
            default:     wb_data = alu_result_i;
        endcase
    end

    // x0 never written, so it reads zero after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_i != '0) begin
            regs[rd_i] <= wb_data;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];
    assign gp_o       = regs[REG_GP];

endmodule
